/* Makefile */
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing -Wall
TOP       := core_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG) || { echo "simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/rv32i_fetch.sv
logic/rv32i_regfile.sv
logic/rv32i_decode.sv
logic/rv32i_execute.sv
logic/rv32i_core.sv
tests/core_tb.sv

/* logic/isa_pkg.sv */
////////////////////
// RV32I instruction set definitions shared by decode and the datapath.
// Holds the data and register index types, the major opcodes and the
// ALU funct3 codes, and the instruction word seen as R-type or I-type.
////////////////////

package isa_pkg;

  localparam int xlen       = 32;                  // data width
  localparam int reg_addr_w = 5;                   // register index width

  typedef logic [xlen-1:0]       word_t;           // one data word
  typedef logic [reg_addr_w-1:0] reg_addr_t;       // one register index

  // major opcodes kept by this core
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,                       // register-immediate arithmetic
    OPC_OP     = 7'b0110011,                       // register-register arithmetic
    OPC_LUI    = 7'b0110111                        // load upper immediate
  } opcode_e;

  // ALU function codes, shared by OP and OP_IMM
  typedef enum logic [2:0] {
    F3_ADD_SUB = 3'b000,
    F3_SLL     = 3'b001,
    F3_SLT     = 3'b010,
    F3_SLTU    = 3'b011,
    F3_XOR     = 3'b100,
    F3_SRL_SRA = 3'b101,
    F3_OR      = 3'b110,
    F3_AND     = 3'b111
  } funct3_e;

  localparam logic [6:0] F7_BASE = 7'b0000000;     // add, srl and the rest
  localparam logic [6:0] F7_ALT  = 7'b0100000;     // sub and sra

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    funct3_e    funct3;
    reg_addr_t  rd;
    opcode_e    opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm12;                            // sign-extended by decode
    reg_addr_t   rs1;
    funct3_e     funct3;
    reg_addr_t   rd;
    opcode_e     opcode;
  } i_type_t;

  // one instruction word, two field layouts
  typedef union packed {
    r_type_t r;
    i_type_t i;
  } instr_u;

endpackage

/* logic/pipe_pkg.sv */
////////////////////
// Pipeline bundles passed between the stages of the core.
// The fetched word goes from fetch to execute, the decoded bundle stays
// inside execute, and the retire record leaves the core.
////////////////////

package pipe_pkg;

  import isa_pkg::*;

  // internal ALU operation, independent of the encoding
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_IMM                                   // lui, result is the immediate
  } alu_op_e;

  typedef struct packed {
    logic   valid;                                 // one cycle per accepted word
    word_t  pc;                                    // address of instr
    instr_u instr;
  } fetched_t;

  typedef struct packed {
    alu_op_e   alu_op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     imm;                                // extended immediate
    logic      use_imm;                            // second operand is imm
    logic      writes_rd;
    logic      illegal;
  } decoded_t;

  typedef struct packed {
    logic      valid;                              // one pulse per instruction
    word_t     pc;
    reg_addr_t rd;
    word_t     data;                               // value written to rd
    logic      writes_rd;                          // low for x0 and illegal
    logic      illegal;
  } retire_t;

endpackage

/* logic/rv32i_core.sv */
////////////////////
// Top level of the three-stage RV32I core.
// Connects fetch, the base register file and execute. Instruction
// memory sits outside, and retired instructions leave on o_retire.
////////////////////

`timescale 1ns/10ps

module rv32i_core
  import isa_pkg::*, pipe_pkg::*;
#(
  parameter word_t PC_RESET = '0
) (
  input  logic    i_clk,
  input  logic    i_reset,
  input  word_t   i_instr,                         // instruction memory reply
  input  logic    i_ack_instr,
  output word_t   o_iaddr,                         // instruction memory request
  output logic    o_stb_instr,
  output retire_t o_retire
);

  fetched_t  fetched;                              // fetch to execute
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;
  logic      wr_en;                                // writeback to regfile
  reg_addr_t wr_addr;
  word_t     wr_data;

  rv32i_fetch #(
    .PC_RESET (PC_RESET)
  ) fetch_i (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_instr     (i_instr),
    .i_ack_instr (i_ack_instr),
    .o_iaddr     (o_iaddr),
    .o_stb_instr (o_stb_instr),
    .o_fetched   (fetched)
  );

  rv32i_regfile regfile_i (
    .i_clk      (i_clk),
    .i_rs1_addr (rs1_addr),
    .i_rs2_addr (rs2_addr),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_wr_en    (wr_en),
    .i_wr_addr  (wr_addr),
    .i_wr_data  (wr_data)
  );

  rv32i_execute execute_i (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_fetched  (fetched),
    .o_rs1_addr (rs1_addr),
    .o_rs2_addr (rs2_addr),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_wr_en    (wr_en),
    .o_wr_addr  (wr_addr),
    .o_wr_data  (wr_data),
    .o_retire   (o_retire)
  );

endmodule

/* logic/rv32i_decode.sv */
////////////////////
// Combinational decoder for OP, OP_IMM and LUI.
// Picks the R or I field layout by opcode, builds the immediate and
// the ALU operation, and flags every other encoding as illegal.
////////////////////

`timescale 1ns/10ps

module rv32i_decode
  import isa_pkg::*, pipe_pkg::*;
(
  input  instr_u   i_instr,
  output decoded_t o_decoded
);

  // funct3 to ALU op, alt selects sub or sra
  function automatic alu_op_e alu_from_f3(funct3_e f3, logic alt);
    alu_op_e op;
    case (f3)
      F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     op = ALU_SLL;
      F3_SLT:     op = ALU_SLT;
      F3_SLTU:    op = ALU_SLTU;
      F3_XOR:     op = ALU_XOR;
      F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      op = ALU_OR;
      F3_AND:     op = ALU_AND;
      default:    op = ALU_ADD;
    endcase
    return op;
  endfunction

  logic       r_alt;                               // funct7 is 0x20
  logic [6:0] shamt_hi;                            // upper imm bits of a shift

  assign r_alt    = (i_instr.r.funct7 == F7_ALT);
  assign shamt_hi = i_instr.i.imm12[11:5];

  always_comb begin
    o_decoded           = '0;
    o_decoded.rd        = i_instr.r.rd;
    o_decoded.imm       = {{(xlen-12){i_instr.i.imm12[11]}}, i_instr.i.imm12}; // sign extend
    o_decoded.alu_op    = ALU_ADD;
    case (i_instr.r.opcode)
      OPC_OP: begin                                // R view
        o_decoded.rs1       = i_instr.r.rs1;
        o_decoded.rs2       = i_instr.r.rs2;
        o_decoded.alu_op    = alu_from_f3(i_instr.r.funct3, r_alt);
        o_decoded.writes_rd = 1'b1;
        if ((i_instr.r.funct7 != F7_BASE) &&
            !(r_alt && (i_instr.r.funct3 inside {F3_ADD_SUB, F3_SRL_SRA}))) begin
          o_decoded.illegal = 1'b1;                // only sub and sra take 0x20
        end
      end
      OPC_OP_IMM: begin                            // I view, rs2 left at x0
        o_decoded.rs1       = i_instr.i.rs1;
        o_decoded.use_imm   = 1'b1;
        o_decoded.writes_rd = 1'b1;
        o_decoded.alu_op    = alu_from_f3(i_instr.i.funct3,
          (i_instr.i.funct3 == F3_SRL_SRA) && (shamt_hi == F7_ALT));
        if ((i_instr.i.funct3 == F3_SLL) && (shamt_hi != F7_BASE)) begin
          o_decoded.illegal = 1'b1;                // slli needs zero upper bits
        end
        if ((i_instr.i.funct3 == F3_SRL_SRA) &&
            (shamt_hi != F7_BASE) && (shamt_hi != F7_ALT)) begin
          o_decoded.illegal = 1'b1;                // neither srli nor srai
        end
      end
      OPC_LUI: begin
        o_decoded.imm       = {i_instr.i.imm12, i_instr.i.rs1, i_instr.i.funct3, 12'h000};
        o_decoded.use_imm   = 1'b1;
        o_decoded.writes_rd = 1'b1;
        o_decoded.alu_op    = ALU_PASS_IMM;        // upper imm goes straight to rd
      end
      default: begin
        o_decoded.illegal = 1'b1;                  // unsupported opcode
      end
    endcase
    if (o_decoded.illegal) begin
      o_decoded.writes_rd = 1'b0;
    end
  end

endmodule

/* logic/rv32i_execute.sv */
////////////////////
// Execute and writeback. Decodes the fetched word, reads operands,
// runs the ALU and registers the retire record, which also drives
// the register file write in the following cycle.
////////////////////

`timescale 1ns/10ps

module rv32i_execute
  import isa_pkg::*, pipe_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset,
  input  fetched_t  i_fetched,
  output reg_addr_t o_rs1_addr,
  output reg_addr_t o_rs2_addr,
  input  word_t     i_rs1_data,                    // bypassed by regfile
  input  word_t     i_rs2_data,
  output logic      o_wr_en,
  output reg_addr_t o_wr_addr,
  output word_t     o_wr_data,
  output retire_t   o_retire
);

  decoded_t   dec;
  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;                               // low 5 bits only
  word_t      alu_y;
  retire_t    retire_q;

  rv32i_decode decode_i (
    .i_instr   (i_fetched.instr),
    .o_decoded (dec)
  );

  assign o_rs1_addr = dec.rs1;
  assign o_rs2_addr = dec.rs2;
  assign op_a       = i_rs1_data;
  assign op_b       = dec.use_imm ? dec.imm : i_rs2_data; // imm or register
  assign shamt      = op_b[4:0];

  ////////////////////
  // ALU
  ////////////////////
  always_comb begin
    case (dec.alu_op)
      ALU_ADD:      alu_y = op_a + op_b;
      ALU_SUB:      alu_y = op_a - op_b;
      ALU_SLL:      alu_y = op_a << shamt;
      ALU_SLT:      alu_y = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:     alu_y = {{(xlen-1){1'b0}}, op_a < op_b};
      ALU_XOR:      alu_y = op_a ^ op_b;
      ALU_SRL:      alu_y = op_a >> shamt;
      ALU_SRA:      alu_y = word_t'($signed(op_a) >>> shamt);
      ALU_OR:       alu_y = op_a | op_b;
      ALU_AND:      alu_y = op_a & op_b;
      ALU_PASS_IMM: alu_y = dec.imm;               // lui
      default:      alu_y = '0;
    endcase
  end

  ////////////////////
  // writeback register
  ////////////////////
  always_ff @(posedge i_clk) begin
    retire_q.pc      <= i_fetched.pc;
    retire_q.rd      <= dec.rd;
    retire_q.data    <= alu_y;
    retire_q.illegal <= dec.illegal;
    if (i_reset) begin
      retire_q.valid     <= 1'b0;
      retire_q.writes_rd <= 1'b0;
    end else begin
      retire_q.valid     <= i_fetched.valid;
      retire_q.writes_rd <= i_fetched.valid && dec.writes_rd &&
                            (dec.rd != '0);        // x0 never written
    end
  end

  assign o_wr_en   = retire_q.writes_rd;           // write lands on the next edge
  assign o_wr_addr = retire_q.rd;
  assign o_wr_data = retire_q.data;
  assign o_retire  = retire_q;

  // decode clears writes_rd on every illegal word
  a_illegal_no_write : assert property (@(posedge i_clk) disable iff (i_reset)
    o_retire.valid && o_retire.illegal |-> !o_retire.writes_rd);

endmodule

/* logic/rv32i_fetch.sv */
////////////////////
// Fetch stage. Keeps the program counter, holds a request level to the
// instruction memory and moves on by one word per acknowledge.
// Each accepted word is registered with its address for execute.
////////////////////

`timescale 1ns/10ps

module rv32i_fetch
  import isa_pkg::*, pipe_pkg::*;
#(
  parameter word_t PC_RESET = '0
) (
  input  logic     i_clk,
  input  logic     i_reset,
  input  word_t    i_instr,                        // word returned by memory
  input  logic     i_ack_instr,                    // one-cycle acknowledge
  output word_t    o_iaddr,                        // request address
  output logic     o_stb_instr,                    // request level
  output fetched_t o_fetched                       // to execute
);

  word_t    pc_q;                                  // address of pending request
  logic     stb_q;
  logic     accept;                                // request ends this cycle
  fetched_t fetched_q;

  assign accept = stb_q && i_ack_instr;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      stb_q <= 1'b0;
      pc_q  <= PC_RESET;
    end else begin
      stb_q <= 1'b1;                               // request from first cycle out of reset
      if (accept) begin
        pc_q <= pc_q + word_t'(4);                 // next sequential word
      end
    end
  end

  ////////////////////
  // instruction register
  ////////////////////
  always_ff @(posedge i_clk) begin
    fetched_q.pc    <= pc_q;
    fetched_q.instr <= i_instr;
    if (i_reset) begin
      fetched_q.valid <= 1'b0;
    end else begin
      fetched_q.valid <= accept;                   // pulse per acknowledge
    end
  end

  assign o_iaddr     = pc_q;
  assign o_stb_instr = stb_q;
  assign o_fetched   = fetched_q;

  // memory may take several cycles, the address must hold until ack
  a_addr_stable : assert property (@(posedge i_clk) disable iff (i_reset)
    o_stb_instr && !i_ack_instr |=> $stable(o_iaddr));

endmodule

/* logic/rv32i_regfile.sv */
////////////////////
// Base register file, x1 to x31, with x0 read as zero.
// Both reads are combinational and see the write of the same cycle,
// which covers the one hazard between execute and writeback.
////////////////////

`timescale 1ns/10ps

module rv32i_regfile
  import isa_pkg::*;
(
  input  logic      i_clk,
  input  reg_addr_t i_rs1_addr,
  input  reg_addr_t i_rs2_addr,
  output word_t     o_rs1_data,
  output word_t     o_rs2_data,
  input  logic      i_wr_en,                       // from writeback register
  input  reg_addr_t i_wr_addr,
  input  word_t     i_wr_data
);

  word_t regs_q [1:31];                            // no storage for x0

  // one read port, shared by rs1 and rs2
  function automatic word_t read_port(reg_addr_t addr);
    word_t data;
    if (addr == '0) begin
      data = '0;                                   // x0 is hardwired
    end else if (i_wr_en && (i_wr_addr == addr)) begin
      data = i_wr_data;                            // write-through
    end else begin
      data = regs_q[addr];
    end
    return data;
  endfunction

  always_ff @(posedge i_clk) begin
    if (i_wr_en && (i_wr_addr != '0)) begin        // writes to x0 dropped
      regs_q[i_wr_addr] <= i_wr_data;
    end
  end

  always_comb begin
    o_rs1_data = read_port(i_rs1_addr);
    o_rs2_data = read_port(i_rs2_addr);
  end

  a_wr_addr_known : assert property (@(posedge i_clk)
    i_wr_en |-> !$isunknown(i_wr_addr));

endmodule

/* tests/core_tb.sv */
////////////////////
// Testbench for the three-stage RV32I core.
// An instruction memory model acks after a random latency, a register
// model predicts each retire, and directed tests run programs in turn.
////////////////////

`timescale 1ns/10ps

module core_tb
  import isa_pkg::*, pipe_pkg::*;
();

  localparam word_t      PC_RESET        = 32'h0000_0000;
  localparam time        clk_period      = 10;
  localparam int         reset_cycles    = 5;
  localparam time        total_instr     = 313;           // all programs together
  localparam time        watchdog_cycles = total_instr * 5 + 400;
  localparam logic [6:0] opc_imm         = 7'h13;
  localparam logic [6:0] opc_op          = 7'h33;
  localparam logic [6:0] opc_lui         = 7'h37;

  logic    i_clk       = 1'b0;
  logic    i_reset     = 1'b1;
  word_t   i_instr     = '0;
  logic    i_ack_instr = 1'b0;
  word_t   o_iaddr;
  logic    o_stb_instr;
  retire_t o_retire;

  word_t       prog_q[$];                                  // program of the running test
  word_t       model_regs[32];                             // reference register file
  time         ack_times[$];                               // negedge of each driven ack
  int unsigned max_lat      = 0;
  logic        mem_on       = 1'b0;
  logic        mem_busy     = 1'b0;
  int unsigned wait_left    = 0;
  word_t       mem_idx;
  int unsigned acks         = 0;
  int unsigned retired      = 0;
  logic        back_to_back = 1'b0;                        // expect one retire per cycle
  time         last_retire  = 0;
  time         ack_t;
  retire_t     exp_ret;
  int unsigned checks       = 0;
  int unsigned errors       = 0;
  int unsigned tests_run    = 0;
  int unsigned tests_failed = 0;

  rv32i_core #(
    .PC_RESET (PC_RESET)
  ) dut_i (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_instr     (i_instr),
    .i_ack_instr (i_ack_instr),
    .o_iaddr     (o_iaddr),
    .o_stb_instr (o_stb_instr),
    .o_retire    (o_retire)
  );

  initial begin
    forever #(clk_period / 2) i_clk = ~i_clk;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired after %0d cycles, the run did not complete", watchdog_cycles);
    $display("** FAIL **");
    $finish;
  end

  task automatic compare(input string name, input word_t got, input word_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic require(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("error at %0t: %s", $time, what);
    end
  endtask

  ////////////////////
  // encoders and reference model
  ////////////////////
  function automatic word_t r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                   input logic [4:0] rs1, input logic [2:0] f3,
                                   input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic word_t i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                   input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, opc_imm};
  endfunction

  function automatic word_t lui_word(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, opc_lui};
  endfunction

  // applies the RV32I rules to one word against the model registers
  function automatic retire_t model_retire(input word_t pc, input word_t w);
    retire_t    r;
    logic [6:0] f7;
    logic [2:0] f3;
    word_t      a;
    word_t      b;
    logic       legal;
    f7      = w[31:25];
    f3      = w[14:12];
    a       = model_regs[w[19:15]];
    b       = (w[6:0] == opc_op) ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
    legal   = 1'b1;
    r       = '0;
    r.valid = 1'b1;
    r.pc    = pc;
    r.rd    = w[11:7];
    case (w[6:0])
      opc_lui: r.data = {w[31:12], 12'h000};
      opc_op, opc_imm: begin
        if (w[6:0] == opc_op) begin
          legal = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
        end else if (f3 == 3'd1) begin
          legal = (f7 == 7'h00);                           // slli
        end else if (f3 == 3'd5) begin
          legal = (f7 == 7'h00) || (f7 == 7'h20);          // srli or srai
        end
        case (f3)
          3'd0:    r.data = ((w[6:0] == opc_op) && f7[5]) ? a - b : a + b;
          3'd1:    r.data = a << b[4:0];
          3'd2:    r.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          3'd3:    r.data = (a < b) ? 32'd1 : 32'd0;
          3'd4:    r.data = a ^ b;
          3'd5:    r.data = f7[5] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
          3'd6:    r.data = a | b;
          default: r.data = a & b;
        endcase
      end
      default: legal = 1'b0;                               // anything else is illegal
    endcase
    r.illegal   = !legal;
    r.writes_rd = legal && (r.rd != 5'd0);
    return r;
  endfunction

  function automatic word_t random_legal();
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      w;
    rd  = 5'($urandom);
    rs1 = 5'($urandom);
    rs2 = 5'($urandom);
    f3  = 3'($urandom);
    f7  = (((f3 == 3'd0) || (f3 == 3'd5)) && ($urandom % 2 == 1)) ? 7'h20 : 7'h00;
    case ($urandom % 3)
      0: w = r_word(f7, rs2, rs1, f3, rd);
      1: begin
        if ((f3 == 3'd1) || (f3 == 3'd5)) begin
          w = i_word({((f3 == 3'd5) ? f7 : 7'h00), rs2}, rs1, f3, rd); // shift amount
        end else begin
          w = i_word(12'($urandom), rs1, f3, rd);
        end
      end
      default: w = lui_word(20'($urandom), rd);
    endcase
    return w;
  endfunction

  ////////////////////
  // instruction memory model and retire checker
  ////////////////////
  always @(negedge i_clk) begin
    i_ack_instr = 1'b0;
    i_instr     = '0;
    if (i_reset || !mem_on) begin
      mem_busy = 1'b0;
    end else if (o_stb_instr) begin
      mem_idx = (o_iaddr - PC_RESET) >> 2;
      if (mem_idx < prog_q.size()) begin                   // no ack past the end
        if (!mem_busy) begin
          mem_busy  = 1'b1;
          wait_left = (max_lat == 0) ? 0 : $urandom % (max_lat + 1);
        end
        if (wait_left == 0) begin
          compare("o_iaddr", o_iaddr, PC_RESET + word_t'(4 * acks));
          i_ack_instr = 1'b1;
          i_instr     = prog_q[mem_idx];
          ack_times.push_back($time);
          acks++;
          mem_busy = 1'b0;
        end else begin
          wait_left--;
        end
      end
    end
  end

  always @(negedge i_clk) begin
    if (!i_reset && (o_retire.valid === 1'b1)) begin
      if (retired >= prog_q.size()) begin
        require(1'b0, "retire seen after the last instruction of the program");
      end else begin
        exp_ret = model_retire(PC_RESET + word_t'(4 * retired), prog_q[retired]);
        compare("o_retire.pc", o_retire.pc, exp_ret.pc);
        compare("o_retire.rd", word_t'(o_retire.rd), word_t'(exp_ret.rd));
        compare("o_retire.writes_rd", word_t'(o_retire.writes_rd), word_t'(exp_ret.writes_rd));
        compare("o_retire.illegal", word_t'(o_retire.illegal), word_t'(exp_ret.illegal));
        if (!exp_ret.illegal) begin
          compare("o_retire.data", o_retire.data, exp_ret.data);
        end
        if (exp_ret.writes_rd) begin
          model_regs[exp_ret.rd] = exp_ret.data;
        end
      end
      if (ack_times.size() == 0) begin
        require(1'b0, "retire without an acknowledge before it");
      end else begin
        ack_t = ack_times.pop_front();
        require($time - ack_t == 2 * clk_period, "retire not two cycles after its acknowledge");
      end
      if (back_to_back && (retired > 0)) begin
        require($time - last_retire == clk_period, "retires not one per cycle");
      end
      last_retire = $time;
      retired++;
    end
  end

  ////////////////////
  // test sequencing
  ////////////////////
  task automatic hold_in_reset();
    @(negedge i_clk);
    i_reset = 1'b1;
    mem_on  = 1'b0;                                        // program changes under reset
    prog_q.delete();
  endtask

  task automatic run_program(input int unsigned lat, input logic in_step);
    repeat (reset_cycles) @(negedge i_clk);
    require(!o_stb_instr, "instruction request active during reset");
    require(!o_retire.valid, "retire valid during reset");
    ack_times.delete();
    acks         = 0;
    retired      = 0;
    max_lat      = lat;
    back_to_back = in_step;
    i_reset      = 1'b0;
    mem_on       = 1'b1;
    @(negedge i_clk);
    require(o_stb_instr, "no instruction request in the first cycle after reset");
    compare("o_iaddr", o_iaddr, PC_RESET);
    while (retired < prog_q.size()) begin
      @(negedge i_clk);
    end
    repeat (4) @(negedge i_clk);                           // a stray retire shows up here
  endtask

  task automatic report_test(input string name, input int unsigned errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s passed, %0d retires", name, retired);
    end else begin
      tests_failed++;
      $display("test %s failed, %0d errors", name, errors - errs_before);
    end
  endtask

  // fills x1 to x31 for the later tests
  task automatic reset_and_fetch();
    int unsigned errs;
    errs = errors;
    hold_in_reset();
    for (int i = 1; i < 32; i++) begin
      prog_q.push_back(i_word(12'(i * 37 - 500), 5'd0, 3'd0, 5'(i)));
    end
    run_program(3, 1'b0);
    report_test("reset and fetch", errs);
  endtask

  task automatic immediate_ops();
    int unsigned errs;
    errs = errors;
    hold_in_reset();
    prog_q.push_back(i_word(12'hff9, 5'd1, 3'd0, 5'd5));   // addi -7
    prog_q.push_back(i_word(12'hffd, 5'd5, 3'd2, 5'd6));   // slti -3
    prog_q.push_back(i_word(12'h005, 5'd5, 3'd3, 5'd7));   // sltiu
    prog_q.push_back(i_word(12'hfff, 5'd2, 3'd4, 5'd8));   // xori -1
    prog_q.push_back(i_word(12'h0f0, 5'd3, 3'd6, 5'd9));   // ori
    prog_q.push_back(i_word(12'hff0, 5'd4, 3'd7, 5'd10));  // andi -16
    prog_q.push_back(i_word(12'h007, 5'd5, 3'd1, 5'd11));  // slli 7
    prog_q.push_back(i_word(12'h003, 5'd5, 3'd5, 5'd12));  // srli 3
    prog_q.push_back(i_word(12'h403, 5'd5, 3'd5, 5'd13));  // srai 3
    prog_q.push_back(lui_word(20'hfedcb, 5'd14));
    prog_q.push_back(i_word(12'h7ff, 5'd14, 3'd0, 5'd14)); // addi onto lui
    prog_q.push_back(i_word(12'h41f, 5'd14, 3'd5, 5'd15)); // srai 31
    prog_q.push_back(i_word(12'h001, 5'd15, 3'd2, 5'd16)); // slti 1
    run_program(3, 1'b0);
    report_test("immediate ops", errs);
  endtask

  // each word reads the previous result through the bypass
  task automatic register_chain();
    int unsigned errs;
    errs = errors;
    hold_in_reset();
    prog_q.push_back(lui_word(20'h89abc, 5'd1));
    prog_q.push_back(i_word(12'hedd, 5'd1, 3'd0, 5'd1));
    prog_q.push_back(r_word(7'h00, 5'd1, 5'd1, 3'd0, 5'd2));   // add
    prog_q.push_back(r_word(7'h20, 5'd31, 5'd2, 3'd0, 5'd3));  // sub
    prog_q.push_back(r_word(7'h00, 5'd30, 5'd3, 3'd1, 5'd4));  // sll
    prog_q.push_back(r_word(7'h00, 5'd3, 5'd4, 3'd2, 5'd5));   // slt
    prog_q.push_back(r_word(7'h00, 5'd4, 5'd5, 3'd3, 5'd6));   // sltu
    prog_q.push_back(r_word(7'h00, 5'd1, 5'd6, 3'd4, 5'd7));   // xor
    prog_q.push_back(r_word(7'h00, 5'd29, 5'd7, 3'd5, 5'd8));  // srl
    prog_q.push_back(r_word(7'h20, 5'd8, 5'd1, 3'd5, 5'd9));   // sra by previous result
    prog_q.push_back(r_word(7'h00, 5'd8, 5'd9, 3'd6, 5'd10));  // or
    prog_q.push_back(r_word(7'h00, 5'd7, 5'd10, 3'd7, 5'd11)); // and
    run_program(0, 1'b1);
    report_test("register chain", errs);
  endtask

  task automatic x0_writes();
    int unsigned errs;
    errs = errors;
    hold_in_reset();
    prog_q.push_back(i_word(12'd123, 5'd5, 3'd0, 5'd0));
    prog_q.push_back(lui_word(20'habcde, 5'd0));
    prog_q.push_back(r_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
    prog_q.push_back(r_word(7'h00, 5'd0, 5'd0, 3'd0, 5'd17)); // x0 reads back zero
    prog_q.push_back(i_word(12'hfff, 5'd0, 3'd0, 5'd18));
    prog_q.push_back(r_word(7'h00, 5'd3, 5'd0, 3'd6, 5'd19));
    run_program(0, 1'b1);
    report_test("x0 writes", errs);
  endtask

  task automatic illegal_words();
    int unsigned errs;
    errs = errors;
    hold_in_reset();
    prog_q.push_back({20'h00002, 5'd20, 7'h03});               // load
    prog_q.push_back({20'h00000, 5'd21, 7'h6f});               // jal
    prog_q.push_back(32'hffff_ffff);
    prog_q.push_back(r_word(7'h20, 5'd2, 5'd1, 3'd4, 5'd22));  // xor with alt funct7
    prog_q.push_back(r_word(7'h01, 5'd2, 5'd1, 3'd0, 5'd23));  // mul
    prog_q.push_back(i_word({7'h20, 5'd3}, 5'd1, 3'd1, 5'd24)); // slli with bad upper bits
    prog_q.push_back(i_word({7'h10, 5'd3}, 5'd1, 3'd5, 5'd25)); // neither srli nor srai
    prog_q.push_back(i_word(12'h000, 5'd20, 3'd0, 5'd26));     // read back the targets
    prog_q.push_back(r_word(7'h00, 5'd22, 5'd21, 3'd0, 5'd27));
    prog_q.push_back(r_word(7'h00, 5'd24, 5'd23, 3'd6, 5'd28));
    prog_q.push_back(r_word(7'h00, 5'd31, 5'd25, 3'd4, 5'd29));
    run_program(2, 1'b0);
    report_test("illegal words", errs);
  endtask

  task automatic random_mix(input string name, input int n, input int unsigned lat);
    int unsigned errs;
    errs = errors;
    hold_in_reset();
    for (int i = 0; i < n; i++) begin
      prog_q.push_back(random_legal());
    end
    run_program(lat, lat == 0);
    report_test(name, errs);
  endtask

  initial begin
    void'($urandom(32'hc35a_b647));                        // one seed for the whole run
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    reset_and_fetch();
    immediate_ops();
    register_chain();
    x0_writes();
    illegal_words();
    random_mix("random mix", 200, 3);
    random_mix("zero latency", 40, 0);
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if ((errors == 0) && (tests_failed == 0)) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
